// File: Bender.yml
package:
  name: noc_ring

sources:
  - files:
      - common/noc_pkg.sv
      - hdl/apb_regs.sv
      - hdl/run_sequencer.sv
      - node/traffic_source.sv
      - node/ring_router.sv
      - hdl/noc_top.sv

  - target: test
    include_dirs:
      - sim
    files:
      - sim/noc_tb.sv

// File: common/noc_pkg.sv
package noc_pkg;

    // ring size and node ids
    localparam int NUM_NODES = 4;
    localparam int NODE_W    = 2;
    typedef logic [NODE_W-1:0] node_id_t;

    // packet length in flits, 1 to 15
    localparam int FLEN_W = 4;
    typedef logic [FLEN_W-1:0] flit_len_t;

    // packet descriptor, destination above length
    localparam int PKT_DESC_W  = NODE_W + FLEN_W;
    localparam int PKT_LEN_LSB = 0;
    localparam int PKT_DST_LSB = FLEN_W;
    typedef logic [PKT_DESC_W-1:0] pkt_desc_t;

    // flit layout {valid, head, tail, dst}
    localparam int FLIT_W       = 5;
    localparam int FLIT_DST_LSB = 0;
    localparam int FLIT_TAIL    = NODE_W;
    localparam int FLIT_HEAD    = NODE_W + 1;
    localparam int FLIT_VALID   = NODE_W + 2;
    typedef logic [FLIT_W-1:0] flit_t;

    localparam int QUEUE_DEPTH = 8;  // descriptors per source
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    localparam int CYCLE_W = 16;
    typedef logic [CYCLE_W-1:0] cycle_t;

    localparam int COUNT_W = 16;
    typedef logic [COUNT_W-1:0] count_t;

    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    // address span of the routing table and of a per-node word block
    localparam int RT_SPAN_W   = $clog2(NUM_NODES * 16);
    localparam int NODE_SPAN_W = $clog2(NUM_NODES * 4);

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_RUN    = 2'd1,
        SEQ_FINISH = 2'd2
    } seq_state_t;

    // register map
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL      = 12'h000;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS    = 12'h004;
    localparam logic [APB_ADDR_W-1:0] ADDR_MAX_CYCLE = 12'h008;
    localparam logic [APB_ADDR_W-1:0] ADDR_CYCLE     = 12'h00C;
    localparam logic [APB_ADDR_W-1:0] ADDR_RT_BASE   = 12'h100;
    localparam logic [APB_ADDR_W-1:0] ADDR_PUSH_BASE = 12'h200;
    localparam logic [APB_ADDR_W-1:0] ADDR_FLITS_BASE = 12'h300;
    localparam logic [APB_ADDR_W-1:0] ADDR_PKTS_BASE = 12'h340;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;
    localparam int STAT_RUNNING_BIT   = 0;
    localparam int STAT_DONE_BIT      = 1;
    localparam int STAT_TIMED_OUT_BIT = 2;

endpackage

// File: hdl/apb_regs.sv
`timescale 1ns/1ps

module apb_regs
    import noc_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic [APB_ADDR_W-1:0]               paddr_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [APB_DATA_W-1:0]               pwdata_i,
    input  cycle_t                              cycle_i,
    input  seq_state_t                          state_i,
    input  logic                                timed_out_i,
    input  logic [NUM_NODES-1:0]                full_i,
    input  count_t [NUM_NODES-1:0]              flits_i,
    input  count_t [NUM_NODES-1:0]              pkts_i,
    output logic [APB_DATA_W-1:0]               prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output logic                                start_o,
    output logic                                clear_o,
    output cycle_t                              max_cycle_o,
    output logic [NUM_NODES-1:0][NUM_NODES-1:0] eject_map_o,
    output logic [NUM_NODES-1:0]                push_o,
    output pkt_desc_t                           push_desc_o
);

    logic access;
    logic wr_ok;
    logic running;
    logic ctrl_hit, status_hit, max_hit, cycle_hit;
    logic rt_hit, push_hit, flits_hit, pkts_hit;
    logic mapped;
    logic err;
    node_id_t rt_node;
    node_id_t word_node;  // node index within a per-node block
    cycle_t max_cycle_q;
    logic [NUM_NODES-1:0][NUM_NODES-1:0] rt_q;

    assign access  = psel_i & penable_i;
    assign running = (state_i == SEQ_RUN);

    assign rt_node   = paddr_i[NODE_SPAN_W +: NODE_W];
    assign word_node = paddr_i[2 +: NODE_W];

    assign ctrl_hit   = (paddr_i == ADDR_CTRL);
    assign status_hit = (paddr_i == ADDR_STATUS);
    assign max_hit    = (paddr_i == ADDR_MAX_CYCLE);
    assign cycle_hit  = (paddr_i == ADDR_CYCLE);
    assign rt_hit    = (paddr_i[APB_ADDR_W-1:RT_SPAN_W] == ADDR_RT_BASE[APB_ADDR_W-1:RT_SPAN_W])
                       && (paddr_i[1:0] == 2'b00);
    assign push_hit  = (paddr_i[APB_ADDR_W-1:NODE_SPAN_W] ==
                        ADDR_PUSH_BASE[APB_ADDR_W-1:NODE_SPAN_W]) && (paddr_i[1:0] == 2'b00);
    assign flits_hit = (paddr_i[APB_ADDR_W-1:NODE_SPAN_W] ==
                        ADDR_FLITS_BASE[APB_ADDR_W-1:NODE_SPAN_W]) && (paddr_i[1:0] == 2'b00);
    assign pkts_hit  = (paddr_i[APB_ADDR_W-1:NODE_SPAN_W] ==
                        ADDR_PKTS_BASE[APB_ADDR_W-1:NODE_SPAN_W]) && (paddr_i[1:0] == 2'b00);

    assign mapped = ctrl_hit | status_hit | max_hit | cycle_hit
                  | rt_hit | push_hit | flits_hit | pkts_hit;

    // config is frozen during a run, and a push must find room
    assign err = access & (~mapped
               | (pwrite_i & running & (rt_hit | push_hit | max_hit))
               | (pwrite_i & push_hit & full_i[word_node]));

    assign wr_ok     = access & pwrite_i & ~err;
    assign pready_o  = 1'b1;  // zero wait
    assign pslverr_o = err;

    // one-cycle strobes where clear wins over start
    assign clear_o = wr_ok & ctrl_hit & pwdata_i[CTRL_CLEAR_BIT];
    assign start_o = wr_ok & ctrl_hit & pwdata_i[CTRL_START_BIT] & ~pwdata_i[CTRL_CLEAR_BIT];
    assign push_o  = (wr_ok & push_hit) ? (NUM_NODES'(1) << word_node) : '0;
    assign push_desc_o = pwdata_i[PKT_DESC_W-1:0];

    assign max_cycle_o = max_cycle_q;
    assign eject_map_o = rt_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            max_cycle_q <= '1;
            for (int n = 0; n < NUM_NODES; n++)
            begin
                rt_q[n] <= NUM_NODES'(1) << n;  // home ejection
            end
        end
        else
        begin
            if (wr_ok && max_hit)
                max_cycle_q <= pwdata_i[CYCLE_W-1:0];
            if (wr_ok && rt_hit)
                rt_q[rt_node][word_node] <= pwdata_i[0];
        end
    end

    always_comb
    begin
        prdata_o = '0;
        if (status_hit)
        begin
            prdata_o[STAT_RUNNING_BIT]   = running;
            prdata_o[STAT_DONE_BIT]      = (state_i == SEQ_FINISH) & ~timed_out_i;
            prdata_o[STAT_TIMED_OUT_BIT] = timed_out_i;
        end
        else if (max_hit)
            prdata_o[CYCLE_W-1:0] = max_cycle_q;
        else if (cycle_hit)
            prdata_o[CYCLE_W-1:0] = cycle_i;
        else if (rt_hit)
            prdata_o[0] = rt_q[rt_node][word_node];
        else if (flits_hit)
            prdata_o[COUNT_W-1:0] = flits_i[word_node];
        else if (pkts_hit)
            prdata_o[COUNT_W-1:0] = pkts_i[word_node];
    end

    // a clear strobe always lands the sequencer in idle
    a_clear_idles: assert property (@(posedge clk) disable iff (reset)
        clear_o |=> (state_i == SEQ_IDLE))
        else $error("clear strobe left the sequencer out of idle");

endmodule

// File: hdl/noc_top.sv
`timescale 1ns/1ps

module noc_top
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    logic start;
    logic clear;
    logic run;
    logic timed_out;
    cycle_t max_cycle;
    cycle_t cycle;
    seq_state_t state;
    pkt_desc_t push_desc;
    logic [NUM_NODES-1:0][NUM_NODES-1:0] eject_map;
    logic [NUM_NODES-1:0] push;
    logic [NUM_NODES-1:0] full;
    logic [NUM_NODES-1:0] src_busy;
    logic [NUM_NODES-1:0] rtr_busy;
    logic [NUM_NODES-1:0] accept;
    count_t [NUM_NODES-1:0] flits;
    count_t [NUM_NODES-1:0] pkts;
    flit_t [NUM_NODES-1:0] src_flit;
    flit_t [NUM_NODES-1:0] ring;  // ring[n] is the link out of node n

    apb_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .cycle_i     (cycle),
        .state_i     (state),
        .timed_out_i (timed_out),
        .full_i      (full),
        .flits_i     (flits),
        .pkts_i      (pkts),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .start_o     (start),
        .clear_o     (clear),
        .max_cycle_o (max_cycle),
        .eject_map_o (eject_map),
        .push_o      (push),
        .push_desc_o (push_desc)
    );

    run_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start),
        .clear_i     (clear),
        .max_cycle_i (max_cycle),
        .busy_i      (src_busy | rtr_busy),
        .run_o       (run),
        .cycle_o     (cycle),
        .state_o     (state),
        .timed_out_o (timed_out)
    );

    for (genvar n = 0; n < NUM_NODES; n++)
    begin : g_node
        traffic_source u_src (
            .clk         (clk),
            .reset       (reset),
            .clear_i     (clear),
            .push_i      (push[n]),
            .push_desc_i (push_desc),
            .run_i       (run),
            .accept_i    (accept[n]),
            .full_o      (full[n]),
            .busy_o      (src_busy[n]),
            .flit_o      (src_flit[n])
        );

        ring_router u_rtr (
            .clk         (clk),
            .reset       (reset),
            .clear_i     (clear),
            .run_i       (run),
            .eject_map_i (eject_map[n]),
            .ring_i      (ring[(n + NUM_NODES - 1) % NUM_NODES]),  // wraps to last node
            .local_i     (src_flit[n]),
            .ring_o      (ring[n]),
            .accept_o    (accept[n]),
            .busy_o      (rtr_busy[n]),
            .flits_o     (flits[n]),
            .pkts_o      (pkts[n])
        );
    end

endmodule

// File: hdl/run_sequencer.sv
`timescale 1ns/1ps

module run_sequencer
    import noc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_i,
    input  logic                 clear_i,
    input  cycle_t               max_cycle_i,
    input  logic [NUM_NODES-1:0] busy_i,
    output logic                 run_o,
    output cycle_t               cycle_o,
    output seq_state_t           state_o,
    output logic                 timed_out_o
);

    seq_state_t state_q;
    cycle_t cycle_q;
    cycle_t cycle_next;
    logic timed_out_q;

    assign cycle_next = cycle_q + 1'b1;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_q     <= SEQ_IDLE;
            cycle_q     <= '0;
            timed_out_q <= 1'b0;
        end
        else if (clear_i)  // only way out of finish
        begin
            state_q     <= SEQ_IDLE;
            cycle_q     <= '0;
            timed_out_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                SEQ_IDLE:
                begin
                    if (start_i)
                    begin
                        state_q     <= SEQ_RUN;
                        cycle_q     <= '0;
                        timed_out_q <= 1'b0;
                    end
                end
                SEQ_RUN:
                begin
                    cycle_q <= cycle_next;
                    if (cycle_next >= max_cycle_i)
                    begin
                        state_q     <= SEQ_FINISH;
                        timed_out_q <= 1'b1;
                    end
                    else if (busy_i == '0)
                        state_q <= SEQ_FINISH;  // network drained
                end
                SEQ_FINISH: ;  // hold results
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    assign run_o       = (state_q == SEQ_RUN);
    assign cycle_o     = cycle_q;
    assign state_o     = state_q;
    assign timed_out_o = timed_out_q;

    // max_cycle is write-protected in the register block during a run
    a_cycle_le_max: assert property (@(posedge clk) disable iff (reset)
        (state_q == SEQ_RUN) |-> (cycle_q <= max_cycle_i))
        else $error("cycle counter passed max_cycle");

endmodule

// File: node/ring_router.sv
`timescale 1ns/1ps

module ring_router
    import noc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear_i,
    input  logic                 run_i,
    input  logic [NUM_NODES-1:0] eject_map_i,
    input  flit_t                ring_i,
    input  flit_t                local_i,
    output flit_t                ring_o,
    output logic                 accept_o,
    output logic                 busy_o,
    output count_t               flits_o,
    output count_t               pkts_o
);

    flit_t sel;
    flit_t ring_q;
    node_id_t sel_dst;
    logic sel_valid;
    logic eject;
    logic forward;
    count_t flits_q;
    count_t pkts_q;

    // local only fills an empty ring slot
    assign accept_o  = ~ring_i[FLIT_VALID];
    assign sel       = ring_i[FLIT_VALID] ? ring_i : local_i;
    assign sel_dst   = sel[FLIT_DST_LSB +: NODE_W];
    assign sel_valid = run_i & sel[FLIT_VALID];
    assign eject     = sel_valid & eject_map_i[sel_dst];
    assign forward   = sel_valid & ~eject;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ring_q <= '0;
        else if (clear_i)
            ring_q <= '0;
        else if (run_i)
            ring_q <= forward ? sel : '0;  // one hop per cycle
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            flits_q <= '0;
            pkts_q  <= '0;
        end
        else if (clear_i)
        begin
            flits_q <= '0;
            pkts_q  <= '0;
        end
        else if (eject)
        begin
            flits_q <= flits_q + 1'b1;
            if (sel[FLIT_TAIL])
                pkts_q <= pkts_q + 1'b1;  // packet done on its tail
        end
    end

    assign ring_o  = ring_q;
    assign busy_o  = ring_q[FLIT_VALID];
    assign flits_o = flits_q;
    assign pkts_o  = pkts_q;

    // a local flit held back by ring traffic must wait unchanged
    a_local_held: assert property (@(posedge clk) disable iff (reset)
        (run_i && local_i[FLIT_VALID] && !accept_o && !clear_i) |=> $stable(local_i))
        else $error("local flit changed while refused");

endmodule

// File: node/traffic_source.sv
`timescale 1ns/1ps

module traffic_source
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clear_i,
    input  logic      push_i,
    input  pkt_desc_t push_desc_i,
    input  logic      run_i,
    input  logic      accept_i,
    output logic      full_o,
    output logic      busy_o,
    output flit_t     flit_o
);

    pkt_desc_t queue_mem [QUEUE_DEPTH];
    pkt_desc_t front;
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_PTR_W:0] count_q;
    logic cur_active_q;
    logic cur_head_q;
    node_id_t cur_dst_q;
    flit_len_t cur_rem_q;  // flits left in current packet
    logic tail;
    logic fire;
    logic load;

    assign front  = queue_mem[rd_ptr_q];
    assign full_o = (count_q + cur_active_q == QUEUE_DEPTH);  // packet in flight keeps its slot
    assign busy_o = cur_active_q | (count_q != '0);

    assign tail = (cur_rem_q <= 1);
    assign fire = cur_active_q & accept_i & run_i;
    // next packet moves up when idle or as the tail leaves
    assign load = (~cur_active_q | (fire & tail)) & (count_q != '0);

    assign flit_o[FLIT_VALID] = cur_active_q;
    assign flit_o[FLIT_HEAD]  = cur_head_q;
    assign flit_o[FLIT_TAIL]  = tail;
    assign flit_o[FLIT_DST_LSB +: NODE_W] = cur_dst_q;

    always_ff @(posedge clk)
    begin
        if (push_i)
            queue_mem[wr_ptr_q] <= push_desc_i;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (clear_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (load)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, load})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cur_active_q <= 1'b0;
            cur_head_q   <= 1'b0;
        end
        else if (clear_i)
        begin
            cur_active_q <= 1'b0;
            cur_head_q   <= 1'b0;
        end
        else if (load)
        begin
            cur_active_q <= 1'b1;
            cur_head_q   <= 1'b1;
        end
        else if (fire)
        begin
            cur_head_q <= 1'b0;
            if (tail)
                cur_active_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            cur_dst_q <= front[PKT_DST_LSB +: NODE_W];
            cur_rem_q <= front[PKT_LEN_LSB +: FLEN_W];
        end
        else if (fire)
            cur_rem_q <= cur_rem_q - 1'b1;
    end

    // full pushes are refused with pslverr upstream
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(push_i && full_o))
        else $error("push into full queue");

endmodule

// File: sim/noc_model.svh
`ifndef NOC_MODEL_SVH
`define NOC_MODEL_SVH

// eject bit per router and destination, mirrors what was written over APB
bit eject_table [NUM_NODES][NUM_NODES];

// predicted delivery counts per node
int exp_flits [NUM_NODES];
int exp_pkts [NUM_NODES];

function automatic void clear_expected();
    for (int n = 0; n < NUM_NODES; n++)
    begin
        exp_flits[n] = 0;
        exp_pkts[n]  = 0;
    end
endfunction

// table contents right after reset
function automatic void set_home_tables();
    for (int n = 0; n < NUM_NODES; n++)
    begin
        for (int d = 0; d < NUM_NODES; d++)
            eject_table[n][d] = (n == d);
    end
endfunction

// walk the ring from the source, the first ejecting router takes the packet
function automatic void credit_packet(input int src, input int dst, input int len);
    int node;
    node = src;
    for (int hop = 0; hop < NUM_NODES; hop++)
    begin
        if (eject_table[node][dst])
        begin
            exp_flits[node] += len;
            exp_pkts[node]  += 1;
            return;
        end
        node = (node + 1) % NUM_NODES;  // next node downstream
    end
    $display("packet from node %0d to node %0d finds no ejecting router", src, dst);
    error_count++;
endfunction

`endif

// File: sim/noc_tb.sv
`timescale 1ns/1ps

module noc_tb
    import noc_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int MAX_LEN    = 15;
    // four full queue loads plus the single-queue fill, rounded up
    localparam int TEST_PKTS       = 5 * NUM_NODES * QUEUE_DEPTH;
    localparam int WATCHDOG_CYCLES = TEST_PKTS * MAX_LEN * NUM_NODES + 20000;
    localparam int POLL_LIMIT      = 3000;

    logic clk;
    logic reset;
    logic [APB_ADDR_W-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;

    logic [31:0] lfsr_q;
    int error_count;
    int test_errors;  // error count when the current test began
    int tests_run;
    int tests_failed;
    logic [APB_DATA_W-1:0] rdata;

    `include "noc_model.svh"

    noc_top UUT (
        .clk       (clk),
        .reset     (reset),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < nbits; i++)
        begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        error_count++;
    endtask

    // setup and access phase, then one idle cycle
    task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] wdata, input logic exp_err,
                              output logic [APB_DATA_W-1:0] data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);  // mid access phase
        data = prdata;
        if (pready !== 1'b1)
        begin
            $display("pready low in the access phase at %0t, address 0x%0h", $time, addr);
            error_count++;
        end
        if (pslverr !== exp_err)
            report_mismatch($sformatf("pslverr at 0x%0h", addr), exp_err, pslverr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, input logic exp_err);
        logic [APB_DATA_W-1:0] unused;
        apb_access(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic read_reg(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data);
        apb_access(1'b0, addr, '0, 1'b0, data);
    endtask

    task automatic check_reg(input string name, input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] exp);
        logic [APB_DATA_W-1:0] data;
        read_reg(addr, data);
        if (data !== exp)
            report_mismatch(name, exp, data);
    endtask

    task automatic check_counts();
        for (int n = 0; n < NUM_NODES; n++)
        begin
            check_reg($sformatf("flits[%0d]", n), ADDR_FLITS_BASE + 12'(n * 4), exp_flits[n]);
            check_reg($sformatf("pkts[%0d]", n), ADDR_PKTS_BASE + 12'(n * 4), exp_pkts[n]);
        end
    endtask

    task automatic push_packet(input int node, input int dst, input int len,
                               input logic exp_err);
        write_reg(ADDR_PUSH_BASE + 12'(node * 4), (dst << PKT_DST_LSB) | len, exp_err);
        if (!exp_err)
            credit_packet(node, dst, len);  // refused pushes never reach the ring
    endtask

    // fixed_len of 0 picks random lengths
    task automatic queue_random(input logic fill, input int fixed_len);
        int npkts;
        int dst;
        int len;
        for (int n = 0; n < NUM_NODES; n++)
        begin
            npkts = fill ? QUEUE_DEPTH : int'(rand_bits(3)) + 1;
            for (int k = 0; k < npkts; k++)
            begin
                dst = int'(rand_bits(NODE_W));
                len = fixed_len;
                while (len == 0)
                    len = int'(rand_bits(FLEN_W));
                push_packet(n, dst, len, 1'b0);
            end
        end
    endtask

    task automatic write_table(input int node, input int dst, input logic eject);
        write_reg(ADDR_RT_BASE + 12'(node * 16 + dst * 4), {31'b0, eject}, 1'b0);
        eject_table[node][dst] = eject;
    endtask

    task automatic start_run();
        write_reg(ADDR_CTRL, 32'h1, 1'b0);
    endtask

    task automatic clear_all();
        write_reg(ADDR_CTRL, 32'h2, 1'b0);
        clear_expected();
    endtask

    task automatic wait_run_end();
        logic [APB_DATA_W-1:0] st;
        int polls;
        st    = '0;
        polls = 0;
        while (st[STAT_TIMED_OUT_BIT:STAT_DONE_BIT] == 2'b00 && polls < POLL_LIMIT)
        begin
            read_reg(ADDR_STATUS, st);
            polls++;
        end
        if (st[STAT_TIMED_OUT_BIT:STAT_DONE_BIT] == 2'b00)
        begin
            $display("run still not finished after %0d status polls", polls);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_errors)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        lfsr_q       = 32'h19b9_b13b;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        set_home_tables();
        clear_expected();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_reg("status", ADDR_STATUS, 32'h0);
        check_reg("cycle", ADDR_CYCLE, 32'h0);
        check_counts();
        finish_test("after reset");

        queue_random(1'b0, 0);
        start_run();
        wait_run_end();
        check_reg("status", ADDR_STATUS, 32'h2);
        check_counts();
        finish_test("home ejection");

        clear_all();
        for (int n = 0; n < NUM_NODES; n++)
        begin
            for (int d = 0; d < NUM_NODES; d++)
                write_table(n, d, (n == d) || (rand_bits(1) != 0));
        end
        queue_random(1'b0, 0);
        start_run();
        wait_run_end();
        check_reg("status", ADDR_STATUS, 32'h2);
        check_counts();
        finish_test("remapped tables");

        clear_all();
        write_reg(ADDR_MAX_CYCLE, 32'd3, 1'b0);
        queue_random(1'b1, 0);
        start_run();
        wait_run_end();
        check_reg("status", ADDR_STATUS, 32'h4);
        check_reg("cycle", ADDR_CYCLE, 32'd3);
        clear_all();
        write_reg(ADDR_MAX_CYCLE, 32'hffff, 1'b0);
        finish_test("timeout");

        // long packets keep the run going while the bad writes go in
        queue_random(1'b1, MAX_LEN);
        start_run();
        check_reg("status", ADDR_STATUS, 32'h1);
        push_packet(0, 1, 1, 1'b1);
        write_reg(ADDR_RT_BASE + 12'h004, {31'b0, ~eject_table[0][1]}, 1'b1);
        wait_run_end();
        check_reg("status", ADDR_STATUS, 32'h2);
        check_counts();
        clear_all();
        for (int k = 0; k < QUEUE_DEPTH; k++)
            push_packet(2, int'(rand_bits(NODE_W)), k + 1, 1'b0);
        push_packet(2, 0, 5, 1'b1);  // ninth push
        write_reg(12'h010, 32'h1, 1'b1);
        apb_access(1'b0, 12'h3f0, '0, 1'b1, rdata);
        start_run();
        wait_run_end();
        check_reg("status", ADDR_STATUS, 32'h2);
        check_counts();
        finish_test("error responses");

        clear_all();
        check_reg("status", ADDR_STATUS, 32'h0);
        check_reg("cycle", ADDR_CYCLE, 32'h0);
        check_counts();
        start_run();
        wait_run_end();
        check_reg("status", ADDR_STATUS, 32'h2);
        finish_test("clear");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+sim
common/noc_pkg.sv
hdl/apb_regs.sv
hdl/run_sequencer.sv
node/traffic_source.sv
node/ring_router.sv
hdl/noc_top.sv
sim/noc_tb.sv
